// File: dv/addr_decode_tb.sv
/*
 table-driven testbench for the address-mode stage, one instruction in flight
 random byte gaps and output stalls from a fixed seed, stops at the first mismatch
*/
`timescale 1ns/1ps
`default_nettype none

module addr_decode_tb;
    import x86_addr_pkg::*;

    // one instruction and the descriptor it must give
    typedef struct packed {
        logic [47:0] bytes;
        logic [2:0]  len;
        logic [2:0]  mode;
        logic [2:0]  seg;
        logic        base_present;
        logic [2:0]  base;
        logic        index_present;
        logic [2:0]  index;
        logic [1:0]  scale;
        logic        gpr_present;
        logic [2:0]  gpr;
        logic [1:0]  width;
        logic [1:0]  disp_len;
        logic [31:0] disp;
    } row_t;

    logic        i_clk;
    logic        i_reset;
    logic [7:0]  i_byte;
    logic        i_byte_valid;
    logic        o_byte_ready;
    logic        i_size_32;
    logic        i_w_present;
    logic        i_w;
    logic        o_valid;
    logic        i_ready;
    logic [2:0]  o_seg;
    logic        o_base_present;
    logic [2:0]  o_base;
    logic        o_index_present;
    logic [2:0]  o_index;
    logic [1:0]  o_scale;
    logic [2:0]  o_reg;
    logic        o_gpr_present;
    logic [2:0]  o_gpr;
    logic [1:0]  o_gpr_width;
    logic [1:0]  o_disp_len;
    logic [31:0] o_disp;

    row_t rows[$];
    int   row_idx;
    int   error_count = 0;
    int   total_bytes = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    addr_decode_top u_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: row %0d %s: got %0h, expected %0h",
                     $time, row_idx, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] sext8(input logic [7:0] b);
        return {{24{b[7]}}, b};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] h);
        return {{16{h[15]}}, h};
    endfunction

    // memory operand row without a register operand
    task automatic add_mem(input logic [47:0] bytes, input logic [2:0] len,
                           input logic [2:0] mode, input logic [2:0] seg,
                           input logic bp, input logic [2:0] base, input logic ip,
                           input logic [2:0] index, input logic [1:0] scale,
                           input logic [1:0] dlen, input logic [31:0] disp);
        rows.push_back(row_t'({bytes, len, mode, seg, bp, base, ip, index, scale,
                               1'b0, 3'd0, 2'd0, dlen, disp}));
    endtask

    task automatic build_table();
        int          m;
        int          rm;
        int          mb;
        logic [7:0]  modrm;
        logic [7:0]  d8;
        logic [15:0] d16;
        logic [2:0]  mode;
        logic [2:0]  base;
        logic [2:0]  seg;
        logic        no_base;
        logic [1:0]  width;
        // mod 11 under every mix of size, w-present and w
        // mode bits are {size_32, w_present, w}
        for (mb = 0; mb < 8; mb++) begin
            mode  = 3'(mb);
            modrm = {2'b11, 3'(~mb), 3'(mb)};
            width = (mode[1] && !mode[0]) ? W_8 : (mode[2] ? W_32 : W_16);
            rows.push_back(row_t'({modrm, 40'h0, 3'd1, mode, 3'd0, 1'b0, 3'd0, 1'b0, 3'd0,
                                   2'd0, 1'b1, mode, width, 2'd0, 32'd0}));
        end
        // all 16 bit r/m values under mods 00 01 and 10
        for (m = 0; m < 3; m++) begin
            for (rm = 0; rm < 8; rm++) begin
                modrm   = {2'(m), 3'(rm ^ m), 3'(rm)};
                d8      = rm[0] ? 8'h80 + 8'(rm) : 8'h12 + 8'(rm);
                d16     = {rm[1] ? 8'hf0 + 8'(rm) : 8'h34, 8'h56 + 8'(rm)};
                no_base = (m == 0 && rm == 6);
                // pairs are bx/bp plus si/di, then si, di, bp, bx alone
                if (rm < 4) begin
                    base = rm[1] ? REG_BP : REG_BX;
                end else begin
                    base = (rm == 4) ? REG_SI : (rm == 5) ? REG_DI : (rm == 6) ? REG_BP : REG_BX;
                end
                base = no_base ? 3'd0 : base;
                seg  = (!no_base && base == REG_BP) ? SEG_SS : SEG_DS;
                if (m == 1) begin
                    add_mem({modrm, d8, 32'h0}, 3'd2, 3'b000, seg, !no_base, base, rm < 4,
                            (rm < 4) ? (rm[0] ? REG_DI : REG_SI) : 3'd0, 2'd0, DISP_8, sext8(d8));
                end else if (m == 2 || no_base) begin
                    add_mem({modrm, d16[7:0], d16[15:8], 24'h0}, 3'd3, 3'b000, seg, !no_base,
                            base, rm < 4, (rm < 4) ? (rm[0] ? REG_DI : REG_SI) : 3'd0, 2'd0,
                            DISP_16, sext16(d16));
                end else begin
                    add_mem({modrm, 40'h0}, 3'd1, 3'b000, seg, 1'b1, base, rm < 4,
                            (rm < 4) ? (rm[0] ? REG_DI : REG_SI) : 3'd0, 2'd0, DISP_0, 32'd0);
                end
            end
        end
        // 32 bit without s-i-b
        add_mem({8'h18, 40'h0}, 3'd1, 3'b100, SEG_DS, 1, REG_AX, 0, 0, 0, DISP_0, 0);
        add_mem({8'h05, 32'h78563412, 8'h0}, 3'd5, 3'b100, SEG_DS, 0, 0, 0, 0, 0, DISP_32,
                32'h12345678);
        add_mem({8'h45, 8'hf0, 32'h0}, 3'd2, 3'b100, SEG_SS, 1, REG_BP, 0, 0, 0, DISP_8,
                32'hfffffff0);
        add_mem({8'h93, 32'h11223384, 8'h0}, 3'd5, 3'b110, SEG_DS, 1, REG_BX, 0, 0, 0, DISP_32,
                32'h84332211);
        add_mem({8'had, 32'hfeffffff, 8'h0}, 3'd5, 3'b100, SEG_SS, 1, REG_BP, 0, 0, 0, DISP_32,
                32'hfffffffe);
        add_mem({8'h7e, 8'h7f, 32'h0}, 3'd2, 3'b101, SEG_DS, 1, REG_SI, 0, 0, 0, DISP_8, 32'h7f);
        add_mem({8'h07, 40'h0}, 3'd1, 3'b100, SEG_DS, 1, REG_DI, 0, 0, 0, DISP_0, 0);
        // 32 bit with s-i-b
        add_mem({8'h04, 8'h88, 32'h0}, 3'd2, 3'b100, SEG_DS, 1, REG_AX, 1, REG_CX, 2, DISP_0, 0);
        add_mem({8'h0c, 8'h25, 32'h01000080}, 3'd6, 3'b100, SEG_DS, 0, 0, 0, 0, 0, DISP_32,
                32'h80000001);
        add_mem({8'h44, 8'he5, 8'h9c, 24'h0}, 3'd3, 3'b100, SEG_SS, 1, REG_BP, 0, 0, 3, DISP_8,
                32'hffffff9c);
        add_mem({8'h54, 8'h24, 8'h08, 24'h0}, 3'd3, 3'b100, SEG_SS, 1, REG_SP, 0, 0, 0, DISP_8,
                32'h8);
        add_mem({8'h94, 8'h7b, 32'hefbeadde}, 3'd6, 3'b100, SEG_DS, 1, REG_BX, 1, REG_DI, 1,
                DISP_32, 32'hdeadbeef);
        add_mem({8'h04, 8'hc5, 32'h00100000}, 3'd6, 3'b100, SEG_DS, 0, 0, 1, REG_AX, 3, DISP_32,
                32'h00001000);
    endtask

    task automatic check_fields(input row_t r);
        check_eq(o_seg, r.seg, "segment");
        check_eq(o_base_present, r.base_present, "base present");
        check_eq(o_base, r.base, "base");
        check_eq(o_index_present, r.index_present, "index present");
        check_eq(o_index, r.index, "index");
        check_eq(o_scale, r.scale, "scale");
        // reg field straight from the mod r/m byte
        check_eq(o_reg, r.bytes[45:43], "reg field");
        check_eq(o_gpr_present, r.gpr_present, "gpr present");
        if (r.gpr_present) begin
            check_eq(o_gpr, r.gpr, "gpr");
            check_eq(o_gpr_width, r.width, "gpr width");
        end
        check_eq(o_disp_len, r.disp_len, "disp length");
        check_eq(o_disp, r.disp, "displacement");
    endtask

    // entered and left on a falling edge
    task automatic send_row(input row_t r);
        int k;
        i_size_32   = r.mode[2];
        i_w_present = r.mode[1];
        i_w         = r.mode[0];
        for (k = 0; k < r.len; k++) begin
            repeat ($urandom_range(0, 2)) @(negedge i_clk);
            i_byte       = r.bytes[47 - 8 * k -: 8];
            i_byte_valid = 1'b1;
            while (!o_byte_ready) @(negedge i_clk);
            check_eq(o_valid, 0, "o_valid before final byte");
            @(posedge i_clk);
            @(negedge i_clk);
            i_byte_valid = 1'b0;
        end
        // one cycle after the last accepted byte
        check_eq(o_valid, 1, "o_valid after final byte");
    endtask

    task automatic take_descriptor(input row_t r);
        int stall;
        stall = $urandom_range(0, 3);
        // fields must hold while i_ready is low
        repeat (stall) begin
            check_fields(r);
            // byte and mode inputs wander while no byte is offered
            i_byte                        = 8'($urandom);
            {i_size_32, i_w_present, i_w} = 3'($urandom);
            @(negedge i_clk);
            check_eq(o_valid, 1, "o_valid under stall");
            check_eq(o_byte_ready, 0, "o_byte_ready under stall");
        end
        check_fields(r);
        i_ready = 1'b1;
        @(posedge i_clk);
        @(negedge i_clk);
        i_ready = 1'b0;
        check_eq(o_valid, 0, "o_valid after handshake");
        check_eq(o_byte_ready, 1, "o_byte_ready after handshake");
    endtask

    // hang guard with a limit set once the table is known
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the DUT made no progress within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h8af8820c));
        i_reset      = 1'b1;
        i_byte       = 8'h00;
        i_byte_valid = 1'b0;
        i_size_32    = 1'b0;
        i_w_present  = 1'b0;
        i_w          = 1'b0;
        i_ready      = 1'b0;
        row_idx      = -1;
        build_table();
        foreach (rows[n]) begin
            total_bytes += rows[n].len;
        end
        cycle_limit = total_bytes * 8 + 200;
        repeat (8) @(negedge i_clk);
        i_reset = 1'b0;
        check_eq(o_valid, 0, "o_valid after reset");
        check_eq(o_byte_ready, 1, "o_byte_ready after reset");
        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            send_row(rows[row_idx]);
            take_descriptor(rows[row_idx]);
        end
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
src/x86_addr_pkg.sv
src/modrm_decode.sv
src/sib_decode.sv
src/disp_byte_counter.sv
src/disp_collect.sv
src/addr_byte_fsm.sv
src/addr_decode_top.sv
dv/addr_decode_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run with verilator, pass only when the pass line shows up
verilator --binary --timing -Wno-fatal -f list.f --top-module addr_decode_tb \
    -o addr_decode_sim \
    && ./obj_dir/addr_decode_sim | tee /dev/stderr | grep -qx "Testbench passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

// File: src/addr_byte_fsm.sv
/*
 sequences mod r/m, s-i-b and displacement bytes of one instruction
 decode fields are live from i_byte in the state that takes them, latched after
 one instruction in flight, output back-pressure stalls the byte input
*/
`timescale 1ns/1ps
`default_nettype none

module addr_byte_fsm (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  x86_addr_pkg::addr_byte_u  i_byte,
    input  logic                      i_byte_valid,
    input  logic                      i_ready,
    input  logic                      i_size_32,
    input  logic                      i_w_present,
    input  logic                      i_w,
    input  logic                      i_sib_needed,
    input  x86_addr_pkg::disp_len_e   i_disp_len,
    input  logic                      i_cnt_last,
    output logic                      o_byte_ready,
    output logic                      o_valid,
    output logic [1:0]                o_mod,
    output logic [2:0]                o_rm,
    output logic [2:0]                o_reg,
    output logic [1:0]                o_ss,
    output logic [2:0]                o_index,
    output logic [2:0]                o_base,
    output logic                      o_size_32,
    output logic                      o_w_present,
    output logic                      o_w,
    output logic                      o_sib_used,
    output logic                      o_cnt_load,
    output x86_addr_pkg::disp_len_e   o_cnt_len,
    output logic                      o_cnt_dec,
    output logic                      o_disp_shift,
    output logic                      o_disp_clear
);
    import x86_addr_pkg::*;

    localparam logic [1:0] WAIT_MODRM = 2'd0;
    localparam logic [1:0] WAIT_SIB   = 2'd1;
    localparam logic [1:0] WAIT_DISP  = 2'd2;
    localparam logic [1:0] HOLD       = 2'd3;

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic [1:0] mod_q;
    logic [2:0] rm_q;
    logic [2:0] reg_q;
    logic [1:0] ss_q;
    logic [2:0] index_q;
    logic [2:0] base_q;
    logic       size_32_q;
    logic       w_present_q;
    logic       w_q;
    logic       sib_q;
    logic       in_modrm;
    logic       in_sib;
    logic       byte_accept;
    logic       has_disp;

    assign in_modrm     = (state_q == WAIT_MODRM);
    assign in_sib       = (state_q == WAIT_SIB);
    assign o_byte_ready = (state_q != HOLD);
    assign o_valid      = (state_q == HOLD);
    assign byte_accept  = i_byte_valid && o_byte_ready;

    // decoders see the incoming byte in its own state, zero latency
    assign o_mod       = in_modrm ? i_byte.modrm.mod : mod_q;
    assign o_rm        = in_modrm ? i_byte.modrm.rm : rm_q;
    assign o_size_32   = in_modrm ? i_size_32 : size_32_q;
    assign o_w_present = in_modrm ? i_w_present : w_present_q;
    assign o_w         = in_modrm ? i_w : w_q;
    assign o_ss        = in_sib ? i_byte.sib.ss : ss_q;
    assign o_index     = in_sib ? i_byte.sib.index : index_q;
    assign o_base      = in_sib ? i_byte.sib.base : base_q;
    // reg is only read from the held descriptor
    assign o_reg       = reg_q;
    // selects the s-i-b path while its byte is taken and after
    assign o_sib_used  = in_sib || sib_q;

    // displacement length comes back through the top level mux
    assign has_disp     = (i_disp_len != DISP_0);
    assign o_cnt_len    = i_disp_len;
    assign o_cnt_load   = byte_accept && has_disp && ((in_modrm && !i_sib_needed) || in_sib);
    assign o_cnt_dec    = byte_accept && (state_q == WAIT_DISP);
    assign o_disp_shift = o_cnt_dec;
    assign o_disp_clear = byte_accept && in_modrm;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WAIT_MODRM: begin
                if (byte_accept) begin
                    if (i_sib_needed) begin
                        state_d = WAIT_SIB;
                    end else begin
                        state_d = has_disp ? WAIT_DISP : HOLD;
                    end
                end
            end
            WAIT_SIB: begin
                if (byte_accept) begin
                    state_d = has_disp ? WAIT_DISP : HOLD;
                end
            end
            WAIT_DISP: begin
                // counter flags the final displacement byte
                if (byte_accept && i_cnt_last) begin
                    state_d = HOLD;
                end
            end
            default: begin
                if (i_ready) begin
                    state_d = WAIT_MODRM;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= WAIT_MODRM;
            sib_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // cleared on handshake so WAIT_MODRM always sees the mod r/m path
            if (byte_accept && in_sib) begin
                sib_q <= 1'b1;
            end else if (o_valid && i_ready) begin
                sib_q <= 1'b0;
            end
        end
    end

    // field latches
    always_ff @(posedge i_clk) begin
        if (byte_accept && in_modrm) begin
            mod_q       <= i_byte.modrm.mod;
            rm_q        <= i_byte.modrm.rm;
            reg_q       <= i_byte.modrm.reg_field;
            size_32_q   <= i_size_32;
            w_present_q <= i_w_present;
            w_q         <= i_w;
        end
        if (byte_accept && in_sib) begin
            ss_q    <= i_byte.sib.ss;
            index_q <= i_byte.sib.index;
            base_q  <= i_byte.sib.base;
        end
    end

endmodule

`default_nettype wire

// File: src/addr_decode_top.sv
/*
 address-mode stage, one descriptor per instruction
 i_size_32 selects both address size and default operand size
 no prefixes, segment overrides or immediates
*/
`timescale 1ns/1ps
`default_nettype none

module addr_decode_top (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic [7:0]                i_byte,
    input  logic                      i_byte_valid,
    output logic                      o_byte_ready,
    input  logic                      i_size_32,
    input  logic                      i_w_present,
    input  logic                      i_w,
    output logic                      o_valid,
    input  logic                      i_ready,
    output logic [2:0]                o_seg,
    output logic                      o_base_present,
    output logic [2:0]                o_base,
    output logic                      o_index_present,
    output logic [2:0]                o_index,
    output logic [1:0]                o_scale,
    output logic [2:0]                o_reg,
    output logic                      o_gpr_present,
    output logic [2:0]                o_gpr,
    output x86_addr_pkg::gpr_width_e  o_gpr_width,
    output x86_addr_pkg::disp_len_e   o_disp_len,
    output logic [31:0]               o_disp
);
    import x86_addr_pkg::*;

    // latched or live fields from the sequencer
    logic [1:0] mod;
    logic [2:0] rm;
    logic [1:0] ss;
    logic [2:0] sib_index;
    logic [2:0] sib_base;
    logic       size_32;
    logic       w_present;
    logic       w;
    logic       sib_used;

    // counter and collector control
    logic       cnt_load;
    logic       cnt_dec;
    logic       cnt_last;
    logic       disp_shift;
    logic       disp_clear;
    disp_len_e  cnt_len;

    // mod r/m decode results
    logic       sib_needed;
    logic [2:0] m_seg;
    logic       m_base_present;
    logic [2:0] m_base;
    logic       m_index_present;
    logic [2:0] m_index;
    disp_len_e  m_disp_len;

    // s-i-b decode results
    logic [1:0] s_scale;
    logic       s_index_present;
    logic [2:0] s_index;
    logic       s_base_present;
    logic [2:0] s_base;
    logic [2:0] s_seg;
    disp_len_e  s_disp_len;

    addr_byte_fsm u_fsm (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_byte       (i_byte),
        .i_byte_valid (i_byte_valid),
        .i_ready      (i_ready),
        .i_size_32    (i_size_32),
        .i_w_present  (i_w_present),
        .i_w          (i_w),
        .i_sib_needed (sib_needed),
        .i_disp_len   (o_disp_len),
        .i_cnt_last   (cnt_last),
        .o_byte_ready (o_byte_ready),
        .o_valid      (o_valid),
        .o_mod        (mod),
        .o_rm         (rm),
        .o_reg        (o_reg),
        .o_ss         (ss),
        .o_index      (sib_index),
        .o_base       (sib_base),
        .o_size_32    (size_32),
        .o_w_present  (w_present),
        .o_w          (w),
        .o_sib_used   (sib_used),
        .o_cnt_load   (cnt_load),
        .o_cnt_len    (cnt_len),
        .o_cnt_dec    (cnt_dec),
        .o_disp_shift (disp_shift),
        .o_disp_clear (disp_clear)
    );

    disp_byte_counter u_counter (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_load  (cnt_load),
        .i_len   (cnt_len),
        .i_dec   (cnt_dec),
        .o_last  (cnt_last)
    );

    modrm_decode u_modrm (
        .i_mod           (mod),
        .i_rm            (rm),
        .i_size_32       (size_32),
        .i_w_present     (w_present),
        .i_w             (w),
        .o_sib_needed    (sib_needed),
        .o_seg           (m_seg),
        .o_base_present  (m_base_present),
        .o_base          (m_base),
        .o_index_present (m_index_present),
        .o_index         (m_index),
        .o_gpr_present   (o_gpr_present),
        .o_gpr           (o_gpr),
        .o_gpr_width     (o_gpr_width),
        .o_disp_len      (m_disp_len)
    );

    sib_decode u_sib (
        .i_mod           (mod),
        .i_ss            (ss),
        .i_index         (sib_index),
        .i_base          (sib_base),
        .o_scale         (s_scale),
        .o_index_present (s_index_present),
        .o_index         (s_index),
        .o_base_present  (s_base_present),
        .o_base          (s_base),
        .o_seg           (s_seg),
        .o_disp_len      (s_disp_len)
    );

    disp_collect u_disp (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_clear (disp_clear),
        .i_shift (disp_shift),
        .i_byte  (i_byte),
        .i_len   (o_disp_len),
        .o_disp  (o_disp)
    );

    // s-i-b path overrides the memory fields when its byte was taken
    assign o_seg           = sib_used ? s_seg : m_seg;
    assign o_base_present  = sib_used ? s_base_present : m_base_present;
    assign o_base          = sib_used ? s_base : m_base;
    assign o_index_present = sib_used ? s_index_present : m_index_present;
    assign o_index         = sib_used ? s_index : m_index;
    assign o_scale         = sib_used ? s_scale : 2'b00;
    assign o_disp_len      = sib_used ? s_disp_len : m_disp_len;

endmodule

`default_nettype wire

// File: src/disp_byte_counter.sv
/*
 counts displacement bytes still to come
 load and decrement are never requested together
*/
`timescale 1ns/1ps
`default_nettype none

module disp_byte_counter (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_load,
    input  x86_addr_pkg::disp_len_e i_len,
    input  logic                    i_dec,
    output logic                    o_last
);
    import x86_addr_pkg::*;

    logic [2:0] count_q;

    // one byte left
    assign o_last = (count_q == 3'd1);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            count_q <= 3'd0;
        end else if (i_load) begin
            count_q <= disp_len_bytes(i_len);
        end else if (i_dec && count_q != 3'd0) begin
            count_q <= count_q - 3'd1;
        end
    end

endmodule

`default_nettype wire

// File: src/disp_collect.sv
/*
 collects displacement bytes, least significant first
 o_disp is sign-extended from the length in i_len, zero for no displacement
*/
`timescale 1ns/1ps
`default_nettype none

module disp_collect (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_clear,
    input  logic                    i_shift,
    input  logic [7:0]              i_byte,
    input  x86_addr_pkg::disp_len_e i_len,
    output logic [31:0]             o_disp
);
    import x86_addr_pkg::*;

    logic [31:0] disp_q;

    // newest byte enters at the top, older bytes move down
    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            disp_q <= 32'd0;
        end else if (i_shift) begin
            disp_q <= {i_byte, disp_q[31:8]};
        end
    end

    // short displacements sit in the upper bytes
    always_comb begin
        case (i_len)
            DISP_8:  o_disp = {{24{disp_q[31]}}, disp_q[31:24]};
            DISP_16: o_disp = {{16{disp_q[31]}}, disp_q[31:16]};
            DISP_32: o_disp = disp_q;
            default: o_disp = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/modrm_decode.sv
/*
 combinational mod r/m decode, 16 and 32 bit addressing
 with o_sib_needed high the memory fields here are not meaningful
*/
`timescale 1ns/1ps
`default_nettype none

module modrm_decode (
    input  logic [1:0]              i_mod,
    input  logic [2:0]              i_rm,
    input  logic                    i_size_32,
    input  logic                    i_w_present,
    input  logic                    i_w,
    output logic                    o_sib_needed,
    output logic [2:0]              o_seg,
    output logic                    o_base_present,
    output logic [2:0]              o_base,
    output logic                    o_index_present,
    output logic [2:0]              o_index,
    output logic                    o_gpr_present,
    output logic [2:0]              o_gpr,
    output x86_addr_pkg::gpr_width_e o_gpr_width,
    output x86_addr_pkg::disp_len_e  o_disp_len
);
    import x86_addr_pkg::*;

    logic mod_reg;

    // mod 11 selects a register operand
    assign mod_reg = (i_mod == 2'b11);

    assign o_gpr_present = mod_reg;
    assign o_gpr         = mod_reg ? i_rm : REG_AX;

    // byte op when w is present and clear
    always_comb begin
        if (i_w_present && !i_w) begin
            o_gpr_width = W_8;
        end else if (i_size_32) begin
            o_gpr_width = W_32;
        end else begin
            o_gpr_width = W_16;
        end
    end

    always_comb begin
        // register operand leaves all memory fields at zero
        o_sib_needed    = 1'b0;
        o_seg           = SEG_ES;
        o_base_present  = 1'b0;
        o_base          = REG_AX;
        o_index_present = 1'b0;
        o_index         = REG_AX;
        o_disp_len      = DISP_0;
        if (!mod_reg && !i_size_32) begin
            o_seg          = SEG_DS;
            o_base_present = 1'b1;
            // 16 bit table, pairs first
            case (i_rm)
                3'b000: begin
                    o_base          = REG_BX;
                    o_index_present = 1'b1;
                    o_index         = REG_SI;
                end
                3'b001: begin
                    o_base          = REG_BX;
                    o_index_present = 1'b1;
                    o_index         = REG_DI;
                end
                3'b010: begin
                    o_base          = REG_BP;
                    o_index_present = 1'b1;
                    o_index         = REG_SI;
                end
                3'b011: begin
                    o_base          = REG_BP;
                    o_index_present = 1'b1;
                    o_index         = REG_DI;
                end
                // lone si / di go out as the base
                3'b100: o_base = REG_SI;
                3'b101: o_base = REG_DI;
                3'b110: begin
                    // mod 00 here is a bare disp16
                    o_base_present = (i_mod != 2'b00);
                    o_base         = (i_mod != 2'b00) ? REG_BP : REG_AX;
                end
                default: o_base = REG_BX;
            endcase
            case (i_mod)
                2'b01:   o_disp_len = DISP_8;
                2'b10:   o_disp_len = DISP_16;
                default: o_disp_len = (i_rm == 3'b110) ? DISP_16 : DISP_0;
            endcase
        end else if (!mod_reg) begin
            o_seg = SEG_DS;
            // 32 bit, r/m 100 hands off to the s-i-b byte
            if (i_rm == 3'b100) begin
                o_sib_needed = 1'b1;
            end else if (i_mod == 2'b00 && i_rm == 3'b101) begin
                o_disp_len = DISP_32;
            end else begin
                o_base_present = 1'b1;
                o_base         = i_rm;
            end
            if (i_mod == 2'b01) begin
                o_disp_len = DISP_8;
            end else if (i_mod == 2'b10) begin
                o_disp_len = DISP_32;
            end
        end
        // bp / ebp based access uses the stack segment
        if (o_base_present && o_base == REG_BP) begin
            o_seg = SEG_SS;
        end
    end

endmodule

`default_nettype wire

// File: src/sib_decode.sv
/*
 combinational s-i-b decode, 32 bit addressing only
 i_mod is the mod field of the preceding mod r/m byte
*/
`timescale 1ns/1ps
`default_nettype none

module sib_decode (
    input  logic [1:0]             i_mod,
    input  logic [1:0]             i_ss,
    input  logic [2:0]             i_index,
    input  logic [2:0]             i_base,
    output logic [1:0]             o_scale,
    output logic                   o_index_present,
    output logic [2:0]             o_index,
    output logic                   o_base_present,
    output logic [2:0]             o_base,
    output logic [2:0]             o_seg,
    output x86_addr_pkg::disp_len_e o_disp_len
);
    import x86_addr_pkg::*;

    logic no_base;

    assign o_scale = i_ss;

    // index 100 encodes no index
    assign o_index_present = (i_index != REG_SP);
    assign o_index         = o_index_present ? i_index : REG_AX;

    // base 101 under mod 00 is a bare disp32
    assign no_base        = (i_base == REG_BP) && (i_mod == 2'b00);
    assign o_base_present = !no_base;
    assign o_base         = no_base ? REG_AX : i_base;

    // esp and ebp based go through ss
    assign o_seg = (o_base_present && (o_base == REG_SP || o_base == REG_BP)) ? SEG_SS : SEG_DS;

    always_comb begin
        case (i_mod)
            2'b01:   o_disp_len = DISP_8;
            2'b10:   o_disp_len = DISP_32;
            default: o_disp_len = no_base ? DISP_32 : DISP_0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/x86_addr_pkg.sv
/*
 shared types and codes for the x86 address-mode decoder
 register numbers follow x86 order, 16 and 32 bit names share them
*/
`default_nettype none

package x86_addr_pkg;

    // mod r/m view of a fetched byte
    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_field;
        logic [2:0] rm;
    } modrm_t;

    // s-i-b view of the same byte
    typedef struct packed {
        logic [1:0] ss;
        logic [2:0] index;
        logic [2:0] base;
    } sib_t;

    // state of the sequencer picks the view
    typedef union packed {
        modrm_t modrm;
        sib_t   sib;
    } addr_byte_u;

    // general registers, x86 order
    localparam logic [2:0] REG_AX = 3'd0;
    localparam logic [2:0] REG_CX = 3'd1;
    localparam logic [2:0] REG_DX = 3'd2;
    localparam logic [2:0] REG_BX = 3'd3;
    localparam logic [2:0] REG_SP = 3'd4;
    localparam logic [2:0] REG_BP = 3'd5;
    localparam logic [2:0] REG_SI = 3'd6;
    localparam logic [2:0] REG_DI = 3'd7;

    // sreg encoding
    localparam logic [2:0] SEG_ES = 3'd0;
    localparam logic [2:0] SEG_CS = 3'd1;
    localparam logic [2:0] SEG_SS = 3'd2;
    localparam logic [2:0] SEG_DS = 3'd3;

    typedef enum logic [1:0] {DISP_0, DISP_8, DISP_16, DISP_32} disp_len_e;

    typedef enum logic [1:0] {W_8, W_16, W_32} gpr_width_e;

    // byte count of a displacement code
    function automatic logic [2:0] disp_len_bytes(input disp_len_e len);
        case (len)
            DISP_8:  return 3'd1;
            DISP_16: return 3'd2;
            DISP_32: return 3'd4;
            default: return 3'd0;
        endcase
    endfunction

endpackage

`default_nettype wire
